/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tracker_tb
FILE_LIST = files.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/tracker_defines.svh */
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// ######################################################################
// NoC and log geometry
// ######################################################################

// width of one NoC flit
`define TRACKER_NOC_W 64

// the log holds 2**6 = 64 lines
`define TRACKER_ADDR_W 6

// one log line spans two NoC flits
`define TRACKER_LINE_W 128

// ######################################################################
// this node's position on the NoC
// ######################################################################

`define TRACKER_SRC_X 8'd3
`define TRACKER_SRC_Y 8'd5

`endif

/* common/tracker_pkg.sv */
`include "tracker_defines.svh"

package tracker_pkg;

    // ######################################################################
    // message and select encodings
    // ######################################################################

    typedef enum logic [1:0] {
        READ_REQ  = 2'd0,
        META_REQ  = 2'd1,
        READ_RESP = 2'd2,
        META_RESP = 2'd3
    } tracker_req_e;

    typedef enum logic [1:0] {
        HDR_1   = 2'd0,
        HDR_2   = 2'd1,
        TRACKER = 2'd2,
        DATA    = 2'd3
    } flit_sel_e;

    localparam logic [7:0] TRACKER_MSG = 8'h0d;

    // the FSM and the length field both use the line-to-flit ratio
    localparam int FLITS_PER_LINE = `TRACKER_LINE_W / `TRACKER_NOC_W;
    localparam int FLITS_SHIFT    = $clog2(FLITS_PER_LINE);

    // ######################################################################
    // flit layouts
    // ######################################################################

    localparam int ROUTING_HDR_USED_W = 44;
    localparam int MISC_HDR_USED_W    = 36;

    typedef struct packed {
        logic [7:0]                                   dst_chip_id;
        logic [7:0]                                   dst_x;
        logic [7:0]                                   dst_y;
        logic [3:0]                                   dst_fbits;
        logic [7:0]                                   msg_len;   // flits after this one
        logic [7:0]                                   msg_type;
        logic [`TRACKER_NOC_W-ROUTING_HDR_USED_W-1:0] padding;
    } routing_hdr_flit;

    typedef struct packed {
        logic [7:0]                                src_chip_id;
        logic [7:0]                                src_x;
        logic [7:0]                                src_y;
        logic [3:0]                                src_fbits;
        logic [7:0]                                metadata_flits;
        logic [`TRACKER_NOC_W-MISC_HDR_USED_W-1:0] padding;
    } misc_hdr_flit;

    typedef struct packed {
        tracker_req_e                req_type;
        logic [`TRACKER_ADDR_W-1:0]  start_addr;
        logic [`TRACKER_ADDR_W-1:0]  end_addr;   // one past the last line
    } tracker_flit;

    localparam int TRACKER_FLIT_W = $bits(tracker_flit);

endpackage

/* dv/tracker_tb.sv */
`include "tracker_defines.svh"

module tracker_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LOG_DEPTH      = 1 << `TRACKER_ADDR_W;
    localparam int FLITS_PER_LINE = `TRACKER_LINE_W / `TRACKER_NOC_W;
    localparam int TRK_PAD_W      = `TRACKER_NOC_W - 2 - 2 * `TRACKER_ADDR_W;
    localparam int RESP_WAIT      = 8;
    localparam int MAX_FLITS      = 300;

    typedef struct packed {
        logic                       is_req;
        logic [15:0]                wr_count;
        tracker_pkg::tracker_req_e  req_type;
        logic [`TRACKER_ADDR_W-1:0] start_addr;
        logic [`TRACKER_ADDR_W-1:0] end_addr;
        logic [7:0]                 chip;
        logic [7:0]                 x;
        logic [7:0]                 y;
        logic [3:0]                 fbits;
    } step_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       noc_in_val;
    logic [`TRACKER_NOC_W-1:0]  noc_in_data;
    logic                       noc_out_val;
    logic [`TRACKER_NOC_W-1:0]  noc_out_data;
    logic                       log_wr_val;
    logic [`TRACKER_LINE_W-1:0] log_wr_data;

    logic [`TRACKER_LINE_W-1:0] model_mem [LOG_DEPTH];
    logic [`TRACKER_ADDR_W-1:0] model_wp;
    logic                       model_wrapped;

    step_t                      steps [$];
    logic [`TRACKER_NOC_W-1:0]  exp_flits [$];
    logic [`TRACKER_NOC_W-1:0]  got_flits [$];
    int                         value_errors;
    int                         other_errors;
    int                         watchdog_cycles = 0;

    always #50 clk = ~clk;

    tracker_top tracker_top_i (
        .clk          (clk),
        .rst          (rst),
        .noc_in_val   (noc_in_val),
        .noc_in_data  (noc_in_data),
        .noc_out_val  (noc_out_val),
        .noc_out_data (noc_out_data),
        .log_wr_val   (log_wr_val),
        .log_wr_data  (log_wr_data)
    );

    // ####################################################################
    // stimulus table
    // ####################################################################

    task automatic add_writes(input int count);
        step_t s;
        begin
            s          = '0;
            s.wr_count = 16'(count);
            steps.push_back(s);
        end
    endtask

    task automatic add_request(input tracker_pkg::tracker_req_e req_type,
                               input logic [`TRACKER_ADDR_W-1:0] start_addr,
                               input logic [`TRACKER_ADDR_W-1:0] end_addr,
                               input logic [7:0] chip, input logic [7:0] x,
                               input logic [7:0] y, input logic [3:0] fbits);
        step_t s;
        begin
            s            = '0;
            s.is_req     = 1'b1;
            s.req_type   = req_type;
            s.start_addr = start_addr;
            s.end_addr   = end_addr;
            s.chip       = chip;
            s.x          = x;
            s.y          = y;
            s.fbits      = fbits;
            steps.push_back(s);
        end
    endtask

    task automatic load_steps();
        add_writes(10);
        add_request(tracker_pkg::META_REQ, 6'd0, 6'd0, 8'd1, 8'd2, 8'd4, 4'd3);
        add_request(tracker_pkg::READ_REQ, 6'd2, 6'd7, 8'd0, 8'd6, 8'd1, 4'd0);
        add_request(tracker_pkg::READ_REQ, 6'd5, 6'd5, 8'd0, 8'd6, 8'd1, 4'd0);   // empty range
        add_writes(70);                                                            // log wraps
        add_request(tracker_pkg::META_REQ, 6'd0, 6'd0, 8'd1, 8'd2, 8'd4, 4'd3);
        add_request(tracker_pkg::READ_REQ, 6'd60, 6'd4, 8'd3, 8'd8, 8'd9, 4'd1);
        add_request(tracker_pkg::META_REQ, 6'd0, 6'd0, 8'd2, 8'd9, 8'd10, 4'd5);
        add_request(tracker_pkg::READ_REQ, 6'd14, 6'd16, 8'd7, 8'd11, 8'd12, 4'd6);
        add_request(tracker_pkg::READ_REQ, 6'd62, 6'd1, 8'd4, 8'd13, 8'd14, 4'd7);
    endtask

    function automatic int flits_for_step(input step_t s);
        logic [`TRACKER_ADDR_W-1:0] n_lines;
        begin
            n_lines = s.end_addr - s.start_addr;
            if (!s.is_req) begin
                return int'(s.wr_count);
            end
            if (s.req_type == tracker_pkg::READ_REQ) begin
                return 6 + FLITS_PER_LINE * int'(n_lines);   // 3 in, 3 out, then data
            end
            return 6;
        end
    endfunction

    // ####################################################################
    // drivers, reference model and checker
    // ####################################################################

    task automatic write_lines(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            assert (noc_out_val === 1'b0) else begin   // the reader stays quiet without a request
                value_errors++;
                $display("error: noc_out_val expected %h got %h", 1'b0, noc_out_val);
            end
            log_wr_val  = 1'b1;
            log_wr_data = {$urandom, $urandom, $urandom, $urandom};
            model_mem[model_wp] = log_wr_data;
            if (model_wp == LOG_DEPTH - 1) begin
                model_wrapped = 1'b1;
            end
            model_wp = model_wp + 1'b1;
        end
        @(negedge clk);
        log_wr_val  = 1'b0;
        log_wr_data = '0;
    endtask

    task automatic send_request(input step_t s);
        @(negedge clk);
        noc_in_val  = 1'b1;
        noc_in_data = {8'd0, `TRACKER_SRC_X, `TRACKER_SRC_Y, 4'd0, 8'd2,
                       tracker_pkg::TRACKER_MSG, 20'd0};
        @(negedge clk);
        noc_in_data = {s.chip, s.x, s.y, s.fbits, 8'd0, 28'd0};   // requester's source fields
        @(negedge clk);
        noc_in_data = {s.req_type, s.start_addr, s.end_addr, {TRK_PAD_W{1'b0}}};
        @(negedge clk);
        noc_in_val  = 1'b0;
        noc_in_data = '0;
    endtask

    task automatic predict_response(input step_t s);
        logic [`TRACKER_ADDR_W-1:0] n_lines;
        logic [`TRACKER_ADDR_W-1:0] addr;
        logic [`TRACKER_ADDR_W-1:0] meta_start;
        logic [7:0]                 msg_len;
        logic [`TRACKER_LINE_W-1:0] line;
        begin
            exp_flits.delete();
            n_lines    = s.end_addr - s.start_addr;   // modulo the log depth
            meta_start = model_wrapped ? model_wp + 1'b1 : '0;
            if (s.req_type == tracker_pkg::READ_REQ) begin
                msg_len = 8'(2 + FLITS_PER_LINE * int'(n_lines));
            end else begin
                msg_len = 8'd2;
            end
            exp_flits.push_back({s.chip, s.x, s.y, s.fbits, msg_len,
                                 tracker_pkg::TRACKER_MSG, 20'd0});
            exp_flits.push_back({8'd0, `TRACKER_SRC_X, `TRACKER_SRC_Y, 4'd0, 8'd1, 28'd0});
            if (s.req_type == tracker_pkg::READ_REQ) begin
                exp_flits.push_back({tracker_pkg::READ_RESP, s.start_addr, s.end_addr,
                                     {TRK_PAD_W{1'b0}}});
                addr = s.start_addr;
                for (int i = 0; i < int'(n_lines); i++) begin
                    line = model_mem[addr];
                    for (int f = 0; f < FLITS_PER_LINE; f++) begin
                        exp_flits.push_back(
                            line[`TRACKER_LINE_W-1-f*`TRACKER_NOC_W -: `TRACKER_NOC_W]);
                    end
                    addr = addr + 1'b1;
                end
            end else begin
                exp_flits.push_back({tracker_pkg::META_RESP, meta_start, model_wp,
                                     {TRK_PAD_W{1'b0}}});
            end
        end
    endtask

    task automatic collect_response(input int idx);
        int wait_cycles;
        begin
            got_flits.delete();
            wait_cycles = 0;
            while (!noc_out_val && wait_cycles < RESP_WAIT) begin
                @(negedge clk);
                wait_cycles++;
            end
            assert (wait_cycles == 0) else begin   // first flit is due right after the request
                other_errors++;
                $display("step %0d: response started %0d cycles late", idx, wait_cycles);
            end
            while (noc_out_val && got_flits.size() < MAX_FLITS) begin
                got_flits.push_back(noc_out_data);
                @(negedge clk);
            end
        end
    endtask

    task automatic compare_response(input int idx);
        int n;
        begin
            n = (got_flits.size() < exp_flits.size()) ? got_flits.size() : exp_flits.size();
            assert (got_flits.size() == exp_flits.size()) else begin
                other_errors++;
                $display("step %0d: response had %0d flits where %0d were expected",
                         idx, got_flits.size(), exp_flits.size());
            end
            for (int i = 0; i < n; i++) begin
                assert (got_flits[i] === exp_flits[i]) else begin
                    value_errors++;
                    $display("error: noc_out_data step %0d flit %0d expected %h got %h",
                             idx, i, exp_flits[i], got_flits[i]);
                end
            end
        end
    endtask

    // ####################################################################
    // run
    // ####################################################################

    initial begin
        int total;
        rst          = 1'b1;
        noc_in_val   = 1'b0;
        noc_in_data  = '0;
        log_wr_val   = 1'b0;
        log_wr_data  = '0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(32'h658f));
        for (int i = 0; i < LOG_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        model_wp      = '0;
        model_wrapped = 1'b0;
        load_steps();
        total = 4;   // reset cycles
        foreach (steps[i]) begin
            total += flits_for_step(steps[i]);
        end
        watchdog_cycles = total + 100;

        repeat (4) @(negedge clk);
        rst = 1'b0;

        foreach (steps[i]) begin
            if (steps[i].is_req) begin
                predict_response(steps[i]);
                send_request(steps[i]);
                collect_response(i);
                compare_response(i);
            end else begin
                write_lines(int'(steps[i].wr_count));
            end
        end

        $display("ran %0d steps: %0d value errors, %0d other errors",
                 steps.size(), value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles without the run finishing",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

/* files.f */
+incdir+common
common/tracker_pkg.sv
src/tracker_log_mem.sv
tracker_reader/tracker_width_fix.sv
tracker_reader/tracker_read_datap.sv
tracker_reader/tracker_read_ctrl.sv
src/tracker_top.sv
dv/tracker_tb.sv

/* src/tracker_log_mem.sv */
`include "tracker_defines.svh"

module tracker_log_mem (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       log_wr_val,
    input  logic [`TRACKER_LINE_W-1:0] log_wr_data,

    input  logic [`TRACKER_ADDR_W-1:0] rd_addr,
    output logic [`TRACKER_LINE_W-1:0] rd_data,

    output logic [`TRACKER_ADDR_W-1:0] curr_wr_addr,
    output logic                       has_wrapped
);

    localparam int DEPTH = 1 << `TRACKER_ADDR_W;

    logic [`TRACKER_LINE_W-1:0] mem [DEPTH];
    logic [`TRACKER_ADDR_W-1:0] wr_ptr_reg;
    logic                       wrapped_reg;

    // ######################################################################
    // storage
    // ######################################################################

    always_ff @(posedge clk) begin
        if (log_wr_val) begin
            mem[wr_ptr_reg] <= log_wr_data;
        end
        rd_data <= mem[rd_addr];   // one cycle read latency
    end

    // ######################################################################
    // ring pointer
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_reg  <= '0;
            wrapped_reg <= 1'b0;
        end else if (log_wr_val) begin
            wr_ptr_reg <= wr_ptr_reg + 1'b1;
            if (wr_ptr_reg == '1) begin
                wrapped_reg <= 1'b1;   // sticky until reset
            end
        end
    end

    assign curr_wr_addr = wr_ptr_reg;
    assign has_wrapped  = wrapped_reg;

endmodule

/* src/tracker_top.sv */
`include "tracker_defines.svh"

module tracker_top (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       noc_in_val,
    input  logic [`TRACKER_NOC_W-1:0]  noc_in_data,

    output logic                       noc_out_val,
    output logic [`TRACKER_NOC_W-1:0]  noc_out_data,

    input  logic                       log_wr_val,
    input  logic [`TRACKER_LINE_W-1:0] log_wr_data
);

    logic                       store_hdr2;
    logic                       store_req;
    logic                       incr_rd_addr;
    tracker_pkg::flit_sel_e     flit_sel;
    tracker_pkg::tracker_req_e  req_type;
    logic                       last_entry;
    logic                       load_line;
    logic                       next_flit;
    logic [`TRACKER_ADDR_W-1:0] log_rd_addr;
    logic [`TRACKER_LINE_W-1:0] log_rd_data;
    logic [`TRACKER_ADDR_W-1:0] curr_wr_addr;
    logic                       has_wrapped;
    logic [`TRACKER_NOC_W-1:0]  line_flit_data;

    tracker_read_ctrl tracker_read_ctrl_i (
        .clk               (clk),
        .rst               (rst),
        .noc_in_val        (noc_in_val),
        .noc_out_val       (noc_out_val),
        .datap_req_type    (req_type),
        .datap_last_entry  (last_entry),
        .ctrl_store_hdr2   (store_hdr2),
        .ctrl_store_req    (store_req),
        .ctrl_incr_rd_addr (incr_rd_addr),
        .ctrl_flit_sel     (flit_sel),
        .load_line         (load_line),
        .next_flit         (next_flit)
    );

    tracker_read_datap tracker_read_datap_i (
        .clk               (clk),
        .rst               (rst),
        .noc_in_data       (noc_in_data),
        .noc_out_data      (noc_out_data),
        .line_flit_data    (line_flit_data),
        .log_rd_addr       (log_rd_addr),
        .curr_wr_addr      (curr_wr_addr),
        .has_wrapped       (has_wrapped),
        .ctrl_store_hdr2   (store_hdr2),
        .ctrl_store_req    (store_req),
        .ctrl_incr_rd_addr (incr_rd_addr),
        .ctrl_flit_sel     (flit_sel),
        .datap_req_type    (req_type),
        .datap_last_entry  (last_entry)
    );

    tracker_width_fix tracker_width_fix_i (
        .clk       (clk),
        .rst       (rst),
        .line_data (log_rd_data),
        .load_line (load_line),
        .next_flit (next_flit),
        .flit_data (line_flit_data)
    );

    tracker_log_mem tracker_log_mem_i (
        .clk          (clk),
        .rst          (rst),
        .log_wr_val   (log_wr_val),
        .log_wr_data  (log_wr_data),
        .rd_addr      (log_rd_addr),
        .rd_data      (log_rd_data),
        .curr_wr_addr (curr_wr_addr),
        .has_wrapped  (has_wrapped)
    );

endmodule

/* tracker_reader/tracker_read_ctrl.sv */
`include "tracker_defines.svh"

module tracker_read_ctrl (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     noc_in_val,
    output logic                     noc_out_val,

    input  tracker_pkg::tracker_req_e datap_req_type,
    input  logic                     datap_last_entry,

    output logic                     ctrl_store_hdr2,
    output logic                     ctrl_store_req,
    output logic                     ctrl_incr_rd_addr,
    output tracker_pkg::flit_sel_e   ctrl_flit_sel,

    output logic                     load_line,
    output logic                     next_flit
);

    localparam int CNT_W = (tracker_pkg::FLITS_PER_LINE > 1) ? tracker_pkg::FLITS_SHIFT : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(tracker_pkg::FLITS_PER_LINE - 1);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_HDR2,
        WAIT_REQ,
        SEND_HDR1,
        SEND_HDR2,
        SEND_TRACKER,
        DATA_OUT
    } state_e;

    state_e            state_reg;
    state_e            state_next;
    logic [CNT_W-1:0]  flit_cnt_reg;
    logic [CNT_W-1:0]  flit_cnt_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg    <= IDLE;
            flit_cnt_reg <= '0;
        end else begin
            state_reg    <= state_next;
            flit_cnt_reg <= flit_cnt_next;
        end
    end

    always_comb begin
        state_next        = state_reg;
        flit_cnt_next     = flit_cnt_reg;
        noc_out_val       = 1'b0;
        ctrl_store_hdr2   = 1'b0;
        ctrl_store_req    = 1'b0;
        ctrl_incr_rd_addr = 1'b0;
        ctrl_flit_sel     = tracker_pkg::HDR_1;
        load_line         = 1'b0;
        next_flit         = 1'b0;

        case (state_reg)
            IDLE: begin
                if (noc_in_val) begin
                    state_next = WAIT_HDR2;   // routing header is not needed
                end
            end
            WAIT_HDR2: begin
                if (noc_in_val) begin
                    ctrl_store_hdr2 = 1'b1;
                    state_next      = WAIT_REQ;
                end
            end
            WAIT_REQ: begin
                if (noc_in_val) begin
                    ctrl_store_req = 1'b1;   // also starts the read of start_addr
                    state_next     = SEND_HDR1;
                end
            end
            SEND_HDR1: begin
                noc_out_val   = 1'b1;
                ctrl_flit_sel = tracker_pkg::HDR_1;
                state_next    = SEND_HDR2;
            end
            SEND_HDR2: begin
                noc_out_val   = 1'b1;
                ctrl_flit_sel = tracker_pkg::HDR_2;
                state_next    = SEND_TRACKER;
            end
            SEND_TRACKER: begin
                noc_out_val   = 1'b1;
                ctrl_flit_sel = tracker_pkg::TRACKER;
                flit_cnt_next = '0;
                if ((datap_req_type == tracker_pkg::READ_REQ) && !datap_last_entry) begin
                    load_line  = 1'b1;   // first line has been read by now
                    state_next = DATA_OUT;
                end else begin
                    state_next = IDLE;
                end
            end
            DATA_OUT: begin
                noc_out_val   = 1'b1;
                ctrl_flit_sel = tracker_pkg::DATA;
                if (flit_cnt_reg == '0) begin
                    ctrl_incr_rd_addr = 1'b1;   // fetch the next line early
                end
                if (flit_cnt_reg == LAST_CNT) begin
                    flit_cnt_next = '0;
                    if (datap_last_entry) begin
                        state_next = IDLE;
                    end else begin
                        load_line = 1'b1;
                    end
                end else begin
                    flit_cnt_next = flit_cnt_reg + 1'b1;
                    next_flit     = 1'b1;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

/* tracker_reader/tracker_read_datap.sv */
`include "tracker_defines.svh"

module tracker_read_datap (
    input  logic                       clk,
    input  logic                       rst,

    input  logic [`TRACKER_NOC_W-1:0]  noc_in_data,
    output logic [`TRACKER_NOC_W-1:0]  noc_out_data,

    input  logic [`TRACKER_NOC_W-1:0]  line_flit_data,
    output logic [`TRACKER_ADDR_W-1:0] log_rd_addr,
    input  logic [`TRACKER_ADDR_W-1:0] curr_wr_addr,
    input  logic                       has_wrapped,

    input  logic                       ctrl_store_hdr2,
    input  logic                       ctrl_store_req,
    input  logic                       ctrl_incr_rd_addr,
    input  tracker_pkg::flit_sel_e     ctrl_flit_sel,

    output tracker_pkg::tracker_req_e  datap_req_type,
    output logic                       datap_last_entry
);

    localparam int TRACKER_PAD_W = `TRACKER_NOC_W - tracker_pkg::TRACKER_FLIT_W;

    logic [`TRACKER_ADDR_W-1:0]   rd_addr_reg;
    logic [`TRACKER_ADDR_W-1:0]   rd_addr_next;
    logic [`TRACKER_ADDR_W-1:0]   num_lines;
    logic [7:0]                   num_lines_ext;

    tracker_pkg::tracker_flit     req_flit_reg;
    tracker_pkg::tracker_flit     req_flit_next;
    tracker_pkg::misc_hdr_flit    misc_req_reg;

    tracker_pkg::routing_hdr_flit hdr_1;
    tracker_pkg::misc_hdr_flit    hdr_2;
    tracker_pkg::tracker_flit     read_resp;
    tracker_pkg::tracker_flit     meta_resp;

    // ######################################################################
    // request registers and read address
    // ######################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr_reg <= '0;
        end else begin
            rd_addr_reg <= rd_addr_next;
        end
        req_flit_reg <= req_flit_next;
        if (ctrl_store_hdr2) begin
            misc_req_reg <= noc_in_data;
        end
    end

    assign req_flit_next = ctrl_store_req
                           ? noc_in_data[`TRACKER_NOC_W-1 -: tracker_pkg::TRACKER_FLIT_W]
                           : req_flit_reg;

    assign rd_addr_next = ctrl_store_req    ? req_flit_next.start_addr
                        : ctrl_incr_rd_addr ? rd_addr_reg + 1'b1
                        :                     rd_addr_reg;

    assign log_rd_addr      = rd_addr_next;   // memory output lines up with rd_addr_reg
    assign datap_req_type   = req_flit_reg.req_type;
    assign datap_last_entry = (rd_addr_next == req_flit_reg.end_addr);

    assign num_lines     = req_flit_reg.end_addr - req_flit_reg.start_addr;   // wraps mod 64
    assign num_lines_ext = 8'(num_lines);

    // ######################################################################
    // response flits
    // ######################################################################

    always_comb begin
        hdr_1             = '0;
        hdr_1.dst_chip_id = misc_req_reg.src_chip_id;
        hdr_1.dst_x       = misc_req_reg.src_x;
        hdr_1.dst_y       = misc_req_reg.src_y;
        hdr_1.dst_fbits   = misc_req_reg.src_fbits;
        hdr_1.msg_len     = (datap_req_type == tracker_pkg::READ_REQ)
                            ? 8'd2 + (num_lines_ext << tracker_pkg::FLITS_SHIFT)
                            : 8'd2;
        hdr_1.msg_type    = tracker_pkg::TRACKER_MSG;
    end

    always_comb begin
        hdr_2                = '0;
        hdr_2.src_x          = `TRACKER_SRC_X;
        hdr_2.src_y          = `TRACKER_SRC_Y;
        hdr_2.metadata_flits = 8'd1;
    end

    always_comb begin
        read_resp            = req_flit_reg;
        read_resp.req_type   = tracker_pkg::READ_RESP;

        meta_resp            = '0;
        meta_resp.req_type   = tracker_pkg::META_RESP;
        meta_resp.start_addr = has_wrapped ? curr_wr_addr + 1'b1 : '0;   // oldest valid line
        meta_resp.end_addr   = curr_wr_addr;
    end

    always_comb begin
        case (ctrl_flit_sel)
            tracker_pkg::HDR_1:   noc_out_data = hdr_1;
            tracker_pkg::HDR_2:   noc_out_data = hdr_2;
            tracker_pkg::TRACKER: begin
                if (datap_req_type == tracker_pkg::READ_REQ) begin
                    noc_out_data = {read_resp, {TRACKER_PAD_W{1'b0}}};
                end else begin
                    noc_out_data = {meta_resp, {TRACKER_PAD_W{1'b0}}};
                end
            end
            default:              noc_out_data = line_flit_data;
        endcase
    end

endmodule

/* tracker_reader/tracker_width_fix.sv */
`include "tracker_defines.svh"

module tracker_width_fix (
    input  logic                       clk,
    input  logic                       rst,

    input  logic [`TRACKER_LINE_W-1:0] line_data,
    input  logic                       load_line,
    input  logic                       next_flit,

    output logic [`TRACKER_NOC_W-1:0]  flit_data
);

    logic [`TRACKER_LINE_W-1:0] line_reg;

    // ######################################################################
    // line hold and shift
    // ######################################################################

    // the most significant flit of the line always sits on top, so sending
    // a line is just a sequence of left shifts by one flit width

    always_ff @(posedge clk) begin
        if (rst) begin
            line_reg <= '0;
        end else if (load_line) begin
            line_reg <= line_data;   // a load wins over a shift
        end else if (next_flit) begin
            line_reg <= line_reg << `TRACKER_NOC_W;
        end
    end

    assign flit_data = line_reg[`TRACKER_LINE_W-1 -: `TRACKER_NOC_W];

endmodule
